// ==== source/bvb.sv ====
`timescale 1ns/10ps

module bvb (
	input  logic                                        clk,
	input  logic                                        rst,
	input  logic                                        start,
	input  bvb_pkg::col_id_t [bvb_pkg::NUM_CHANNEL-1:0] id,
	input  bvb_pkg::chan_mask_t                         id_empty,
	output bvb_pkg::chan_mask_t                         id_rd_en,
	output bvb_pkg::vec_val_t [bvb_pkg::NUM_CHANNEL-1:0] val,
	output bvb_pkg::chan_mask_t                         val_empty,
	input  bvb_pkg::chan_mask_t                         val_rd_en,
	input  bvb_pkg::vec_load_t                          load,
	input  logic                                        load_req,
	output logic                                        load_ack
);

	bvb_pkg::col_id_t    lookup_addr;
	bvb_pkg::vec_val_t   rd_data;     // shared by every value FIFO
	bvb_pkg::chan_mask_t val_wr_en;
	bvb_pkg::chan_mask_t full_mask;

	////////////////////////////////////////////////////////////
	// scheduler and vector memory
	////////////////////////////////////////////////////////////

	channel_scheduler u_sched (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.id          (id),
		.id_empty    (id_empty),
		.full_mask   (full_mask),
		.id_rd_en    (id_rd_en),
		.lookup_addr (lookup_addr),
		.val_wr_en   (val_wr_en)
	);

	vector_ram u_ram (
		.clk         (clk),
		.rst         (rst),
		.lookup_addr (lookup_addr),
		.rd_data     (rd_data),
		.load        (load),
		.load_req    (load_req),
		.load_ack    (load_ack)
	);

	////////////////////////////////////////////////////////////
	// per-channel value FIFOs
	////////////////////////////////////////////////////////////

	for (genvar g = 0; g < bvb_pkg::NUM_CHANNEL; g++) begin : g_fifo
		value_fifo u_fifo (
			.clk   (clk),
			.rst   (rst),
			.din   (rd_data),
			.we    (val_wr_en[g]), // only the served channel
			.re    (val_rd_en[g]),
			.dout  (val[g]),
			.full  (full_mask[g]),
			.empty (val_empty[g])
		);
	end

endmodule

// ==== source/bvb_pkg.sv ====
package bvb_pkg;

	////////////////////////////////////////////////////////////
	// channel geometry
	////////////////////////////////////////////////////////////

	localparam int NUM_CHANNEL = 4;                      // at least 3, keeps 3 items apart
	localparam int CHAN_BITS = $clog2(NUM_CHANNEL);      // width of a channel index

	////////////////////////////////////////////////////////////
	// vector memory
	////////////////////////////////////////////////////////////

	localparam int COL_ID_BITS = 8;                      // column id is the RAM address
	localparam int VEC_VAL_BITS = 8;                     // one vector value per word
	localparam int VEC_WORDS = 1 << COL_ID_BITS;         // whole column range

	////////////////////////////////////////////////////////////
	// value FIFOs
	////////////////////////////////////////////////////////////

	localparam int FIFO_DEPTH = 8;                       // power of two
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);         // pointer width, wraps naturally

	////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////

	typedef logic [COL_ID_BITS-1:0] col_id_t;
	typedef logic [VEC_VAL_BITS-1:0] vec_val_t;

	// one bit per channel for empty, full and enable vectors
	typedef logic [NUM_CHANNEL-1:0] chan_mask_t;

	// word presented on the load port
	typedef struct packed {
		col_id_t addr;                                   // RAM word to write
		vec_val_t val;                                   // value stored there
	} vec_load_t;

	// four-phase load handshake
	typedef enum logic {
		LOAD_IDLE = 1'b0,                                // waiting for load_req
		LOAD_ACK = 1'b1                                  // word written, ack held high
	} load_state_t;

endpackage

// ==== source/channel_scheduler.sv ====
`timescale 1ns/10ps

module channel_scheduler (
	input  logic                                            clk,
	input  logic                                            rst,
	input  logic                                            start,
	input  bvb_pkg::col_id_t [bvb_pkg::NUM_CHANNEL-1:0]     id,
	input  bvb_pkg::chan_mask_t                             id_empty,
	input  bvb_pkg::chan_mask_t                             full_mask,
	output bvb_pkg::chan_mask_t                             id_rd_en,
	output bvb_pkg::col_id_t                                lookup_addr,
	output bvb_pkg::chan_mask_t                             val_wr_en
);

	// one item moving down the lookup pipeline
	typedef struct packed {
		logic                          valid;
		logic [bvb_pkg::CHAN_BITS-1:0] chan;
		bvb_pkg::col_id_t              addr;
	} stage_t;

	logic [bvb_pkg::CHAN_BITS-1:0] counter;
	logic                          accept;
	stage_t                        s1;  // address registered, RAM reading
	stage_t                        s2;  // RAM data valid, FIFO write

	////////////////////////////////////////////////////////////
	// round-robin selection
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			counter <= '0;
		end else if (start) begin
			if (counter == bvb_pkg::CHAN_BITS'(bvb_pkg::NUM_CHANNEL - 1)) begin
				counter <= '0;
			end else begin
				counter <= counter + 1'b1;
			end
		end
	end

	// served channel needs an id and room for its value
	assign accept = start && !id_empty[counter] && !full_mask[counter];

	always_comb begin
		id_rd_en = '0;
		id_rd_en[counter] = accept; // at most one bit
	end

	////////////////////////////////////////////////////////////
	// lookup pipeline
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			s1 <= '0;
			s2 <= '0;
		end else if (start) begin
			s1.valid <= accept;
			s1.chan <= counter;
			s1.addr <= id[counter]; // gathered id becomes the RAM address
			s2 <= s1;
		end
	end

	// while stalled, keep re-reading the word of the item waiting
	// to be written so the RAM output does not move on under it
	assign lookup_addr = start ? s1.addr : s2.addr;

	always_comb begin
		val_wr_en = '0;
		val_wr_en[s2.chan] = start && s2.valid; // data at RAM output now
	end

endmodule

// ==== source/value_fifo.sv ====
`timescale 1ns/10ps

module value_fifo (
	input  logic              clk,
	input  logic              rst,
	input  bvb_pkg::vec_val_t din,
	input  logic              we,
	input  logic              re,
	output bvb_pkg::vec_val_t dout,
	output logic              full,
	output logic              empty
);

	////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////

	bvb_pkg::vec_val_t mem [bvb_pkg::FIFO_DEPTH];

	logic [bvb_pkg::FIFO_AW-1:0] wp;
	logic [bvb_pkg::FIFO_AW-1:0] rp;
	logic [bvb_pkg::FIFO_AW-1:0] wp_pl1;
	logic [bvb_pkg::FIFO_AW-1:0] rp_pl1;
	logic                        gb;  // guard bit, tells full from empty

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wp] <= din;
		end
	end

	// head word straight out of the array
	assign dout = mem[rp];

	////////////////////////////////////////////////////////////
	// pointers
	////////////////////////////////////////////////////////////

	assign wp_pl1 = wp + 1'b1; // wraps at FIFO_DEPTH
	assign rp_pl1 = rp + 1'b1;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wp <= '0;
		end else if (we) begin
			wp <= wp_pl1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rp <= '0;
		end else if (re) begin
			rp <= rp_pl1;
		end
	end

	////////////////////////////////////////////////////////////
	// flags
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			gb <= 1'b0;
		end else if (we && !re && (wp_pl1 == rp)) begin
			gb <= 1'b1; // this write fills the last slot
		end else if (re && !we) begin
			gb <= 1'b0; // any pop leaves room
		end
	end

	assign empty = (wp == rp) && !gb;
	assign full = (wp == rp) && gb;

endmodule

// ==== source/vector_ram.sv ====
`timescale 1ns/10ps

module vector_ram (
	input  logic               clk,
	input  logic               rst,
	input  bvb_pkg::col_id_t   lookup_addr,
	output bvb_pkg::vec_val_t  rd_data,
	input  bvb_pkg::vec_load_t load,
	input  logic               load_req,
	output logic               load_ack
);

	////////////////////////////////////////////////////////////
	// load handshake
	////////////////////////////////////////////////////////////

	bvb_pkg::load_state_t state;
	bvb_pkg::load_state_t state_nxt;
	logic                 wr_en;

	always_comb begin
		state_nxt = state;
		case (state)
			bvb_pkg::LOAD_IDLE: begin
				if (load_req) begin
					state_nxt = bvb_pkg::LOAD_ACK; // req seen, write now
				end
			end
			bvb_pkg::LOAD_ACK: begin
				if (!load_req) begin
					state_nxt = bvb_pkg::LOAD_IDLE; // master released req
				end
			end
			default: state_nxt = bvb_pkg::LOAD_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= bvb_pkg::LOAD_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// one write per handshake, on the way into LOAD_ACK
	assign wr_en = (state == bvb_pkg::LOAD_IDLE) && load_req;
	assign load_ack = (state == bvb_pkg::LOAD_ACK);

	////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////

	bvb_pkg::vec_val_t mem [bvb_pkg::VEC_WORDS];

	// single port, a write cycle keeps the last read word on rd_data
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[load.addr] <= load.val;
		end else begin
			rd_data <= mem[lookup_addr]; // one cycle read latency
		end
	end

endmodule

// ==== verif/bvb_chk.sv ====
`timescale 1ns/10ps

module bvb_chk (
	input logic                clk,
	input logic                rst,
	input logic                start,
	input bvb_pkg::chan_mask_t id_empty,
	input bvb_pkg::chan_mask_t id_rd_en,
	input bvb_pkg::chan_mask_t val_empty,
	input bvb_pkg::chan_mask_t val_rd_en,
	input logic                load_req,
	input logic                load_ack
);

	////////////////////////////////////////////////////////////
	// scheduler and FIFO interfaces
	////////////////////////////////////////////////////////////

	a_rd_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(id_rd_en))
		else $error("more than one id_rd_en bit high");

	a_rd_has_id: assert property (@(posedge clk) disable iff (rst)
		(id_rd_en & id_empty) == '0)
		else $error("id_rd_en high on an empty id channel");

	a_pop_has_val: assert property (@(posedge clk) disable iff (rst)
		(val_rd_en & val_empty) == '0)
		else $error("val_rd_en high on an empty value channel");

	////////////////////////////////////////////////////////////
	// load port
	////////////////////////////////////////////////////////////

	a_load_idle: assert property (@(posedge clk) disable iff (rst) !(load_req && start))
		else $error("load_req high while start is high");

	// ack may only drop once req is gone
	a_ack_hold: assert property (@(posedge clk) disable iff (rst)
		(load_ack && load_req) |=> load_ack)
		else $error("load_ack fell while load_req still high");

endmodule

bind bvb bvb_chk u_chk (
	.clk       (clk),
	.rst       (rst),
	.start     (start),
	.id_empty  (id_empty),
	.id_rd_en  (id_rd_en),
	.val_empty (val_empty),
	.val_rd_en (val_rd_en),
	.load_req  (load_req),
	.load_ack  (load_ack)
);

// ==== verif/bvb_tb.sv ====
`timescale 1ns/10ps

module bvb_tb;

	localparam int NCH = bvb_pkg::NUM_CHANNEL;
	localparam int LOAD_TIMEOUT = 20;                  // cycles per handshake phase
	localparam int DRAIN_TIMEOUT = 4000;
	localparam int FILL_TIMEOUT = 400;
	localparam int HOLD_CYCLES = 5 * NCH;              // long enough to see any movement
	localparam int BP_CHAN = 2;                        // channel left undrained
	localparam int BP_EXTRA = 4;                       // ids beyond what its FIFO holds
	localparam bvb_pkg::col_id_t RELOAD_ADDR = 8'h5a;
	localparam bvb_pkg::chan_mask_t ALL_CH = '1;

	typedef struct {
		string            name;
		int               chan;
		bvb_pkg::col_id_t col;
		bit               drain;
	} row_t;

	logic                         clk;
	logic                         rst;
	logic                         start;
	bvb_pkg::col_id_t [NCH-1:0]   id = '0;
	bvb_pkg::chan_mask_t          id_empty = '1;
	bvb_pkg::chan_mask_t          id_rd_en;
	bvb_pkg::vec_val_t [NCH-1:0]  val;
	bvb_pkg::chan_mask_t          val_empty;
	bvb_pkg::chan_mask_t          val_rd_en = '0;
	bvb_pkg::vec_load_t           load;
	logic                         load_req;
	logic                         load_ack;

	bvb_pkg::vec_val_t image [bvb_pkg::VEC_WORDS];     // model of the vector RAM
	bvb_pkg::col_id_t  id_q [NCH][$];                  // external id FIFOs
	bvb_pkg::vec_val_t exp_q [NCH][$];                 // values still owed per channel
	string             exp_name [NCH][$];
	row_t              rows [$];                       // stimulus table
	bit [NCH-1:0]      drain_en = '0;
	integer            seed = 47;
	int                held [NCH];

	bvb DUT (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.id        (id),
		.id_empty  (id_empty),
		.id_rd_en  (id_rd_en),
		.val       (val),
		.val_empty (val_empty),
		.val_rd_en (val_rd_en),
		.load      (load),
		.load_req  (load_req),
		.load_ack  (load_ack)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// checking
	////////////////////////////////////////////////////////////

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("MISMATCH %s: expected %0h, actual %0h",
				name, expected, actual));
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////////////////

	function automatic void add_row(input string name, input int chan, input int col,
			input bit drain);
		row_t r;
		r.name = name;
		r.chan = chan;
		r.col = bvb_pkg::col_id_t'(col);
		r.drain = drain;
		rows.push_back(r);
	endfunction

	task automatic build_table();
		int c;
		for (int a = 0; a < bvb_pkg::VEC_WORDS; a++) begin
			add_row("lookup", a % NCH, a, 1'b1); // every word once
		end
		for (int i = 0; i < 32; i++) begin
			c = $random(seed);
			add_row("spread", i % NCH, c & 8'hff, 1'b1);
		end
		for (int i = 0; i < bvb_pkg::FIFO_DEPTH + BP_EXTRA; i++) begin
			add_row("backpressure", BP_CHAN, i * 7 + 3, 1'b0);
		end
		for (int i = 0; i < 24; i++) begin
			if (i % NCH != BP_CHAN) begin
				add_row("backpressure", i % NCH, i * 11 + 1, 1'b1);
			end
		end
		for (int i = 0; i < 8; i++) begin
			add_row("stall", i % NCH, 255 - i * 3, 1'b1);
		end
		for (int i = 0; i < 6; i++) begin
			add_row("reload", i % NCH, RELOAD_ADDR, 1'b1);
		end
	endtask

	// queue side changes on the falling edge, away from the DUT
	task automatic apply_group(input string name);
		bvb_pkg::col_id_t col;
		int               ch;
		@(negedge clk);
		foreach (rows[i]) begin
			if (rows[i].name == name) begin
				ch = rows[i].chan;
				col = rows[i].col;
				drain_en[ch] = rows[i].drain;
				id_q[ch].push_back(col);
				exp_q[ch].push_back(image[col]); // expected from the model image
				exp_name[ch].push_back(name);
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// id FIFO models and value drainer
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		for (int c = 0; c < NCH; c++) begin
			if (id_rd_en[c]) begin
				if (id_q[c].size() == 0) begin
					stop_with_failure($sformatf("id read from empty channel %0d", c));
				end else begin
					void'(id_q[c].pop_front());
				end
			end
			if (id_q[c].size() > 0) begin
				id[c] <= id_q[c][0];  // fall-through head
				id_empty[c] <= 1'b0;
			end else begin
				id_empty[c] <= 1'b1;
			end
		end
	end

	// pop at most every other cycle so val_empty is current
	always @(posedge clk) begin
		for (int c = 0; c < NCH; c++) begin
			if (val_rd_en[c]) begin
				val_rd_en[c] <= 1'b0;
			end else if (drain_en[c] && !val_empty[c]) begin
				if (exp_q[c].size() == 0) begin
					stop_with_failure($sformatf("unexpected value on channel %0d", c));
				end else begin
					check_value(exp_name[c][0], exp_q[c][0], val[c]);
					void'(exp_q[c].pop_front());
					void'(exp_name[c].pop_front());
					val_rd_en[c] <= 1'b1;
				end
			end
		end
	end

	function automatic bit all_done(input int skip);
		for (int c = 0; c < NCH; c++) begin
			if (c != skip && (exp_q[c].size() != 0 || id_q[c].size() != 0)) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	////////////////////////////////////////////////////////////
	// waits
	////////////////////////////////////////////////////////////

	task automatic load_word(input bvb_pkg::col_id_t a, input bvb_pkg::vec_val_t v);
		int waited;
		@(posedge clk);
		load <= '{addr: a, val: v};
		load_req <= 1'b1;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
			if (waited > LOAD_TIMEOUT) begin
				stop_with_failure($sformatf("load_ack never rose for address %0h", a));
			end
		end while (!load_ack);
		load_req <= 1'b0;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
			if (waited > LOAD_TIMEOUT) begin
				stop_with_failure($sformatf("load_ack never fell for address %0h", a));
			end
		end while (load_ack);
	endtask

	task automatic wait_drained(input string name);
		int waited;
		waited = 0;
		while (!all_done(-1) || val_empty != ALL_CH) begin
			@(negedge clk);
			waited++;
			if (waited > DRAIN_TIMEOUT) begin
				stop_with_failure($sformatf("%s: not all values arrived in time", name));
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int                waited;
		bvb_pkg::vec_val_t fresh;
		rst = 1'b1;
		start = 1'b0;
		load = '0;
		load_req = 1'b0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		check_value("reset", 0, id_rd_en);
		check_value("reset", ALL_CH, val_empty);
		check_value("reset", 0, load_ack);

		for (int a = 0; a < bvb_pkg::VEC_WORDS; a++) begin
			image[a] = bvb_pkg::vec_val_t'($random(seed));
			load_word(bvb_pkg::col_id_t'(a), image[a]);
		end
		build_table();

		@(posedge clk);
		start <= 1'b1;
		apply_group("lookup");
		wait_drained("lookup");
		apply_group("spread");
		wait_drained("spread");

		apply_group("backpressure");
		waited = 0;
		while (id_q[BP_CHAN].size() != BP_EXTRA || !all_done(BP_CHAN)) begin
			@(negedge clk);
			waited++;
			if (waited > FILL_TIMEOUT) begin
				stop_with_failure("backpressure: FIFO of channel 2 did not fill");
			end
		end
		repeat (HOLD_CYCLES) @(negedge clk);
		check_value("backpressure", BP_EXTRA, id_q[BP_CHAN].size());
		check_value("backpressure", 0, val_empty[BP_CHAN]);
		check_value("backpressure", exp_q[BP_CHAN][0], val[BP_CHAN]); // oldest value at head
		drain_en[BP_CHAN] = 1'b1;
		wait_drained("backpressure");

		@(posedge clk);
		start <= 1'b0;
		apply_group("stall");
		for (int c = 0; c < NCH; c++) begin
			held[c] = id_q[c].size();
		end
		repeat (HOLD_CYCLES) @(negedge clk);
		for (int c = 0; c < NCH; c++) begin
			check_value("stall", held[c], id_q[c].size()); // nothing consumed
		end
		check_value("stall", ALL_CH, val_empty);
		@(posedge clk);
		start <= 1'b1;
		wait_drained("stall");

		@(posedge clk);
		start <= 1'b0;
		fresh = ~image[RELOAD_ADDR];
		load_word(RELOAD_ADDR, fresh);
		image[RELOAD_ADDR] = fresh;
		@(posedge clk);
		start <= 1'b1;
		apply_group("reload");
		wait_drained("reload");

		$display("Test OK");
		$finish;
	end

endmodule

// ==== verilog.f ====
source/bvb_pkg.sv
source/vector_ram.sv
source/value_fifo.sv
source/channel_scheduler.sv
source/bvb.sv
verif/bvb_chk.sv
verif/bvb_tb.sv
